//--- hdl/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

//////////////////////////////////////////////////
// Host MMIO port
//////////////////////////////////////////////////

// Word address and data widths
`define MMIO_ADDR_W 24
`define MMIO_DATA_W 64

// One 32-bit half of a doubleword
`define MMIO_HALF_W 32

// Parity error flags (bit 1 data, bit 0 address)
`define MMIO_ERR_W 2

//////////////////////////////////////////////////
// Accelerator descriptor table
//////////////////////////////////////////////////
`define AFU_DESC_WORDS 10
`define AFU_DESC_IDX_W (`MMIO_ADDR_W - 1)

`endif

//--- hdl/mmio_pkg.sv
`include "mmio_params.svh"

package mmio_pkg;

  // Request kind after decoding valid, cfg and read
  typedef enum logic [2:0] {
    op_none      = 3'd0,
    op_cfg_read  = 3'd1,
    op_cfg_write = 3'd2,
    op_reg_read  = 3'd3,
    op_reg_write = 3'd4
  } mmio_op_e;

  //////////////////////////////////////////////////
  // Register map, word addresses
  //////////////////////////////////////////////////
  typedef enum logic [`MMIO_ADDR_W-1:0] {
    // Write side
    AFU_CONFIGURE      = 24'h3F_FF00,
    AFU_CONFIGURE_2    = 24'h3F_FF02,
    CU_CONFIGURE       = 24'h3F_FF04,
    CU_CONFIGURE_2     = 24'h3F_FF06,
    CU_RETURN_DONE_ACK = 24'h3F_FF08,
    ERROR_REG_ACK      = 24'h3F_FF0A,
    // Status read side
    CU_RETURN          = 24'h3F_FF10,
    CU_RETURN_DONE     = 24'h3F_FF12,
    ERROR_REG          = 24'h3F_FF14,
    AFU_STATUS         = 24'h3F_FF16,
    CU_STATUS          = 24'h3F_FF18,
    // Statistics
    DONE_COUNT_REG     = 24'h3F_FF20,
    FLUSHED_COUNT_REG  = 24'h3F_FF22,
    CYCLE_COUNT_REG    = 24'h3F_FF24
  } mmio_reg_e;

  // Bit that makes data plus parity hold an odd number of ones.
  // Narrower fields are zero extended by the caller
  function automatic logic odd_parity(
    input logic [`MMIO_DATA_W-1:0] data
  );
    return ~(^data);
  endfunction

endpackage

//--- hdl/afu_pkg.sv
`include "mmio_params.svh"

package afu_pkg;

  // Descriptor layout, doubleword 0 in the top bits
  typedef struct packed {
    logic [15:0]  num_ints_per_process;
    logic [15:0]  num_of_processes;
    logic [15:0]  num_of_afu_crs;
    logic [15:0]  req_prog_model;
    logic [191:0] reserved_1;
    logic [7:0]   reserved_2;
    logic [55:0]  afu_cr_len;
    logic [63:0]  afu_cr_offset;
    logic [5:0]   reserved_3;
    logic         psa_per_process_required;
    logic         psa_required;
    logic [55:0]  psa_length;
    logic [63:0]  psa_offset;
    logic [7:0]   reserved_4;
    logic [55:0]  afu_eb_len;
    logic [63:0]  afu_eb_offset;
  } afu_desc_t;

  // Single dedicated process with one config record
  parameter afu_desc_t afu_desc_c = '{
    num_ints_per_process     : 16'h0000,
    num_of_processes         : 16'h0001,
    num_of_afu_crs           : 16'h0001,
    req_prog_model           : 16'h8010,
    afu_cr_len               : 56'h00_0000_0000_0001,
    afu_cr_offset            : 64'h0000_0000_0000_0100,
    psa_required             : 1'b1,
    default                  : '0
  };

  function automatic logic [`MMIO_DATA_W-1:0] read_afu_descriptor(
    input logic [`AFU_DESC_IDX_W-1:0] index
  );
    logic [`AFU_DESC_WORDS*`MMIO_DATA_W-1:0] desc_bits;
    int unsigned                             word;
    desc_bits = afu_desc_c;
    if (index >= `AFU_DESC_WORDS) begin
      return '0;
    end
    word = `AFU_DESC_WORDS - 1 - int'(index);
    return desc_bits[word*`MMIO_DATA_W +: `MMIO_DATA_W];
  endfunction

endpackage

//--- hdl/mmio_request_capture.sv
`timescale 1ns/100ps
`include "mmio_params.svh"

module mmio_request_capture (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        mmio_valid,
  input  logic                        mmio_cfg,
  input  logic                        mmio_read,
  input  logic                        mmio_doubleword,
  input  logic [`MMIO_ADDR_W-1:0]     mmio_address,
  input  logic                        mmio_address_parity,
  input  logic [`MMIO_DATA_W-1:0]     mmio_wdata,
  input  logic                        mmio_wdata_parity,
  output mmio_pkg::mmio_op_e          req_op,
  output logic [`MMIO_ADDR_W-1:0]     req_address,
  output logic [`MMIO_DATA_W-1:0]     req_wdata,
  output logic                        req_doubleword,
  output logic                        req_half,
  output logic                        addr_parity_error,
  output logic                        data_parity_error
);

  mmio_pkg::mmio_op_e op_next;
  logic               addr_par_calc;
  logic               data_par_calc;
  logic               is_write;

  //////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////
  always_comb begin
    if (!mmio_valid) begin
      op_next = mmio_pkg::op_none;
    end else if (mmio_cfg) begin
      op_next = mmio_read ? mmio_pkg::op_cfg_read : mmio_pkg::op_cfg_write;
    end else begin
      op_next = mmio_read ? mmio_pkg::op_reg_read : mmio_pkg::op_reg_write;
    end
  end

  assign is_write = mmio_valid && !mmio_read;

  // Expected parity of what the host sent
  assign addr_par_calc = mmio_pkg::odd_parity(
    {{(`MMIO_DATA_W - `MMIO_ADDR_W){1'b0}}, mmio_address}
  );
  assign data_par_calc = mmio_pkg::odd_parity(mmio_wdata);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_op            <= mmio_pkg::op_none;
      addr_parity_error <= 1'b0;
      data_parity_error <= 1'b0;
    end else begin
      req_op            <= op_next;
      addr_parity_error <= mmio_valid && (mmio_address_parity != addr_par_calc);
      // Write data is ignored on reads, so no check there
      data_parity_error <= is_write && (mmio_wdata_parity != data_par_calc);
    end
  end

  //////////////////////////////////////////////////
  // Request payload
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    req_address    <= mmio_valid ? mmio_address : '0;
    req_wdata      <= is_write ? mmio_wdata : '0;
    req_doubleword <= mmio_valid && mmio_doubleword;
    // Address bit 0 picks the low half of a config doubleword
    req_half       <= mmio_valid && mmio_cfg && mmio_address[0];
  end

endmodule

//--- hdl/mmio_register_file.sv
`timescale 1ns/100ps
`include "mmio_params.svh"

module mmio_register_file (
  input  logic                        clock,
  input  logic                        rstn,
  input  mmio_pkg::mmio_op_e          req_op,
  input  logic [`MMIO_ADDR_W-1:0]     req_address,
  input  logic [`MMIO_DATA_W-1:0]     req_wdata,
  input  logic                        req_doubleword,
  input  logic                        req_half,
  input  logic [`MMIO_DATA_W-1:0]     cu_return,
  input  logic [`MMIO_DATA_W-1:0]     cu_return_done,
  input  logic [`MMIO_DATA_W-1:0]     report_errors,
  input  logic [`MMIO_DATA_W-1:0]     afu_status,
  input  logic [`MMIO_DATA_W-1:0]     cu_status,
  input  logic [`MMIO_DATA_W-1:0]     done_count,
  input  logic [`MMIO_DATA_W-1:0]     flushed_count,
  input  logic [`MMIO_DATA_W-1:0]     cycle_count,
  output logic [`MMIO_DATA_W-1:0]     afu_configure,
  output logic [`MMIO_DATA_W-1:0]     afu_configure_2,
  output logic [`MMIO_DATA_W-1:0]     cu_configure,
  output logic [`MMIO_DATA_W-1:0]     cu_configure_2,
  output logic                        cu_return_done_ack,
  output logic                        report_errors_ack,
  output mmio_pkg::mmio_op_e          rd_op,
  output logic [`MMIO_DATA_W-1:0]     rd_data,
  output logic                        rd_doubleword,
  output logic                        rd_half
);

  logic [`MMIO_DATA_W-1:0] cu_return_q;
  logic [`MMIO_DATA_W-1:0] cu_return_done_q;
  logic [`MMIO_DATA_W-1:0] report_errors_q;
  logic [`MMIO_DATA_W-1:0] afu_status_q;
  logic [`MMIO_DATA_W-1:0] cu_status_q;
  logic [`MMIO_DATA_W-1:0] done_count_q;
  logic [`MMIO_DATA_W-1:0] flushed_count_q;
  logic [`MMIO_DATA_W-1:0] cycle_count_q;
  logic [`MMIO_DATA_W-1:0] reg_data;
  logic                    reg_hit;
  mmio_pkg::mmio_op_e      last_read_op;

  // Status sampled every edge
  always_ff @(posedge clock) begin
    cu_return_q      <= cu_return;
    cu_return_done_q <= cu_return_done;
    report_errors_q  <= report_errors;
    afu_status_q     <= afu_status;
    cu_status_q      <= cu_status;
    done_count_q     <= done_count;
    flushed_count_q  <= flushed_count;
    cycle_count_q    <= cycle_count;
  end

  //////////////////////////////////////////////////
  // Write strobes and ack pulses
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      afu_configure      <= '0;
      afu_configure_2    <= '0;
      cu_configure       <= '0;
      cu_configure_2     <= '0;
      cu_return_done_ack <= 1'b0;
      report_errors_ack  <= 1'b0;
    end else begin
      afu_configure      <= '0;
      afu_configure_2    <= '0;
      cu_configure       <= '0;
      cu_configure_2     <= '0;
      cu_return_done_ack <= 1'b0;
      report_errors_ack  <= 1'b0;
      if (req_op == mmio_pkg::op_reg_write) begin
        case (req_address)
          mmio_pkg::AFU_CONFIGURE:      afu_configure      <= req_wdata;
          mmio_pkg::AFU_CONFIGURE_2:    afu_configure_2    <= req_wdata;
          mmio_pkg::CU_CONFIGURE:       cu_configure       <= req_wdata;
          mmio_pkg::CU_CONFIGURE_2:     cu_configure_2     <= req_wdata;
          mmio_pkg::CU_RETURN_DONE_ACK: cu_return_done_ack <= |req_wdata;
          mmio_pkg::ERROR_REG_ACK:      report_errors_ack  <= |req_wdata;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Read selection
  //////////////////////////////////////////////////
  always_comb begin
    reg_hit  = 1'b1;
    reg_data = rd_data;
    case (req_address)
      mmio_pkg::CU_RETURN:         reg_data = cu_return_q;
      mmio_pkg::CU_RETURN_DONE:    reg_data = cu_return_done_q;
      mmio_pkg::ERROR_REG:         reg_data = report_errors_q;
      mmio_pkg::AFU_STATUS:        reg_data = afu_status_q;
      mmio_pkg::CU_STATUS:         reg_data = cu_status_q;
      mmio_pkg::DONE_COUNT_REG:    reg_data = done_count_q;
      mmio_pkg::FLUSHED_COUNT_REG: reg_data = flushed_count_q;
      mmio_pkg::CYCLE_COUNT_REG:   reg_data = cycle_count_q;
      default:                     reg_hit  = 1'b0;
    endcase
  end

  // Unmapped reads replay the last read op with its held data and format,
  // so the host sees the previous response again
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_op         <= mmio_pkg::op_none;
      rd_data       <= '0;
      rd_doubleword <= 1'b1;
      rd_half       <= 1'b0;
      last_read_op  <= mmio_pkg::op_reg_read;
    end else if (req_op == mmio_pkg::op_cfg_read) begin
      rd_op         <= req_op;
      rd_data       <= afu_pkg::read_afu_descriptor(req_address[`MMIO_ADDR_W-1:1]);
      rd_doubleword <= req_doubleword;
      rd_half       <= req_half;
      last_read_op  <= mmio_pkg::op_cfg_read;
    end else if (req_op == mmio_pkg::op_reg_read && reg_hit) begin
      rd_op         <= req_op;
      rd_data       <= reg_data;
      rd_doubleword <= req_doubleword;
      rd_half       <= req_half;
      last_read_op  <= mmio_pkg::op_reg_read;
    end else if (req_op == mmio_pkg::op_reg_read) begin
      rd_op <= last_read_op;
    end else begin
      rd_op <= req_op;
    end
  end

endmodule

//--- hdl/mmio_response.sv
`timescale 1ns/100ps
`include "mmio_params.svh"

module mmio_response (
  input  logic                        clock,
  input  logic                        rstn,
  input  mmio_pkg::mmio_op_e          rd_op,
  input  logic [`MMIO_DATA_W-1:0]     rd_data,
  input  logic                        rd_doubleword,
  input  logic                        rd_half,
  input  logic                        addr_parity_error,
  input  logic                        data_parity_error,
  output logic                        mmio_ack,
  output logic [`MMIO_DATA_W-1:0]     mmio_rdata,
  output logic                        mmio_rdata_parity,
  output logic [`MMIO_ERR_W-1:0]      mmio_errors
);

  logic [`MMIO_DATA_W-1:0] rdata_fmt;
  logic [`MMIO_ERR_W-1:0]  err_stage;
  logic                    is_read;

  // 32-bit config reads return the chosen half in both halves
  always_comb begin
    if (rd_op == mmio_pkg::op_cfg_read && !rd_doubleword) begin
      if (rd_half) begin
        rdata_fmt = {2{rd_data[`MMIO_HALF_W-1:0]}};
      end else begin
        rdata_fmt = {2{rd_data[`MMIO_DATA_W-1:`MMIO_HALF_W]}};
      end
    end else begin
      rdata_fmt = rd_data;
    end
  end

  assign is_read = (rd_op == mmio_pkg::op_cfg_read) || (rd_op == mmio_pkg::op_reg_read);

  //////////////////////////////////////////////////
  // Ack, read data and error flags
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_ack          <= 1'b0;
      mmio_rdata        <= '0;
      mmio_rdata_parity <= 1'b1;
      err_stage         <= '0;
      mmio_errors       <= '0;
    end else begin
      mmio_ack <= (rd_op != mmio_pkg::op_none);
      if (is_read) begin
        mmio_rdata        <= rdata_fmt;
        mmio_rdata_parity <= mmio_pkg::odd_parity(rdata_fmt);
      end
      // Flags are one stage ahead of rd_op
      err_stage   <= {data_parity_error, addr_parity_error};
      mmio_errors <= err_stage;
    end
  end

endmodule

//--- hdl/mmio_top.sv
`timescale 1ns/100ps
`include "mmio_params.svh"

module mmio_top (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        mmio_valid,
  input  logic                        mmio_cfg,
  input  logic                        mmio_read,
  input  logic                        mmio_doubleword,
  input  logic [`MMIO_ADDR_W-1:0]     mmio_address,
  input  logic                        mmio_address_parity,
  input  logic [`MMIO_DATA_W-1:0]     mmio_wdata,
  input  logic                        mmio_wdata_parity,
  input  logic [`MMIO_DATA_W-1:0]     cu_return,
  input  logic [`MMIO_DATA_W-1:0]     cu_return_done,
  input  logic [`MMIO_DATA_W-1:0]     report_errors,
  input  logic [`MMIO_DATA_W-1:0]     afu_status,
  input  logic [`MMIO_DATA_W-1:0]     cu_status,
  input  logic [`MMIO_DATA_W-1:0]     done_count,
  input  logic [`MMIO_DATA_W-1:0]     flushed_count,
  input  logic [`MMIO_DATA_W-1:0]     cycle_count,
  output logic                        mmio_ack,
  output logic [`MMIO_DATA_W-1:0]     mmio_rdata,
  output logic                        mmio_rdata_parity,
  output logic [`MMIO_ERR_W-1:0]      mmio_errors,
  output logic [`MMIO_DATA_W-1:0]     afu_configure,
  output logic [`MMIO_DATA_W-1:0]     afu_configure_2,
  output logic [`MMIO_DATA_W-1:0]     cu_configure,
  output logic [`MMIO_DATA_W-1:0]     cu_configure_2,
  output logic                        cu_return_done_ack,
  output logic                        report_errors_ack
);

  mmio_pkg::mmio_op_e      req_op;
  logic [`MMIO_ADDR_W-1:0] req_address;
  logic [`MMIO_DATA_W-1:0] req_wdata;
  logic                    req_doubleword;
  logic                    req_half;
  logic                    addr_parity_error;
  logic                    data_parity_error;
  mmio_pkg::mmio_op_e      rd_op;
  logic [`MMIO_DATA_W-1:0] rd_data;
  logic                    rd_doubleword;
  logic                    rd_half;

  // Stage 1, host request in
  mmio_request_capture u_capture (
    .clock               (clock),
    .rstn                (rstn),
    .mmio_valid          (mmio_valid),
    .mmio_cfg            (mmio_cfg),
    .mmio_read           (mmio_read),
    .mmio_doubleword     (mmio_doubleword),
    .mmio_address        (mmio_address),
    .mmio_address_parity (mmio_address_parity),
    .mmio_wdata          (mmio_wdata),
    .mmio_wdata_parity   (mmio_wdata_parity),
    .req_op              (req_op),
    .req_address         (req_address),
    .req_wdata           (req_wdata),
    .req_doubleword      (req_doubleword),
    .req_half            (req_half),
    .addr_parity_error   (addr_parity_error),
    .data_parity_error   (data_parity_error)
  );

  // Stage 2, registers and descriptor
  mmio_register_file u_regs (
    .clock              (clock),
    .rstn               (rstn),
    .req_op             (req_op),
    .req_address        (req_address),
    .req_wdata          (req_wdata),
    .req_doubleword     (req_doubleword),
    .req_half           (req_half),
    .cu_return          (cu_return),
    .cu_return_done     (cu_return_done),
    .report_errors      (report_errors),
    .afu_status         (afu_status),
    .cu_status          (cu_status),
    .done_count         (done_count),
    .flushed_count      (flushed_count),
    .cycle_count        (cycle_count),
    .afu_configure      (afu_configure),
    .afu_configure_2    (afu_configure_2),
    .cu_configure       (cu_configure),
    .cu_configure_2     (cu_configure_2),
    .cu_return_done_ack (cu_return_done_ack),
    .report_errors_ack  (report_errors_ack),
    .rd_op              (rd_op),
    .rd_data            (rd_data),
    .rd_doubleword      (rd_doubleword),
    .rd_half            (rd_half)
  );

  // Stage 3, response to host
  mmio_response u_response (
    .clock             (clock),
    .rstn              (rstn),
    .rd_op             (rd_op),
    .rd_data           (rd_data),
    .rd_doubleword     (rd_doubleword),
    .rd_half           (rd_half),
    .addr_parity_error (addr_parity_error),
    .data_parity_error (data_parity_error),
    .mmio_ack          (mmio_ack),
    .mmio_rdata        (mmio_rdata),
    .mmio_rdata_parity (mmio_rdata_parity),
    .mmio_errors       (mmio_errors)
  );

endmodule

//--- dv/mmio_tb.sv
`timescale 1ns/100ps
`include "mmio_params.svh"

module mmio_tb;

  // One issued request as the host should see it
  typedef struct packed {
    int                      ack_cycle;
    logic [`MMIO_DATA_W-1:0] rdata;
    logic [`MMIO_ERR_W-1:0]  errors;
    logic [2:0]              strobe_sel;
    logic [`MMIO_DATA_W-1:0] strobe_data;
    logic                    done_ack;
    logic                    err_ack;
  } expect_t;

  logic                    clock;
  logic                    rstn;
  logic                    mmio_valid;
  logic                    mmio_cfg;
  logic                    mmio_read;
  logic                    mmio_doubleword;
  logic [`MMIO_ADDR_W-1:0] mmio_address;
  logic                    mmio_address_parity;
  logic [`MMIO_DATA_W-1:0] mmio_wdata;
  logic                    mmio_wdata_parity;
  logic [`MMIO_DATA_W-1:0] cu_return;
  logic [`MMIO_DATA_W-1:0] cu_return_done;
  logic [`MMIO_DATA_W-1:0] report_errors;
  logic [`MMIO_DATA_W-1:0] afu_status;
  logic [`MMIO_DATA_W-1:0] cu_status;
  logic [`MMIO_DATA_W-1:0] done_count;
  logic [`MMIO_DATA_W-1:0] flushed_count;
  logic [`MMIO_DATA_W-1:0] cycle_count;
  logic                    mmio_ack;
  logic [`MMIO_DATA_W-1:0] mmio_rdata;
  logic                    mmio_rdata_parity;
  logic [`MMIO_ERR_W-1:0]  mmio_errors;
  logic [`MMIO_DATA_W-1:0] afu_configure;
  logic [`MMIO_DATA_W-1:0] afu_configure_2;
  logic [`MMIO_DATA_W-1:0] cu_configure;
  logic [`MMIO_DATA_W-1:0] cu_configure_2;
  logic                    cu_return_done_ack;
  logic                    report_errors_ack;

  integer                  seed;
  int                      cycle;
  int                      error_count;
  int                      check_count;
  int                      test_start;
  logic                    monitor_on;
  logic [`MMIO_DATA_W-1:0] model_rdata;
  expect_t                 model_q[$];

  mmio_top DUT (.*);

  initial clock = 1'b0;
  always #10 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  always @(negedge clock) begin
    if (monitor_on) begin
      check_cycle();
    end
  end

  //////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////
  function automatic logic calc_odd_parity(input logic [`MMIO_DATA_W-1:0] data);
    int ones;
    ones = 0;
    for (int i = 0; i < `MMIO_DATA_W; i++) begin
      ones += data[i];
    end
    return (ones % 2) == 0;
  endfunction

  // Descriptor doublewords built field by field, reserved bits zero
  function automatic logic [`MMIO_DATA_W-1:0] desc_word(input logic [`AFU_DESC_IDX_W-1:0] idx);
    afu_pkg::afu_desc_t d;
    d = afu_pkg::afu_desc_c;
    case (idx)
      0:       return {d.num_ints_per_process, d.num_of_processes,
                       d.num_of_afu_crs, d.req_prog_model};
      4:       return {8'h00, d.afu_cr_len};
      5:       return d.afu_cr_offset;
      6:       return {6'h00, d.psa_per_process_required, d.psa_required, d.psa_length};
      7:       return d.psa_offset;
      8:       return {8'h00, d.afu_eb_len};
      9:       return d.afu_eb_offset;
      default: return '0;
    endcase
  endfunction

  function automatic logic reg_lookup(input logic [`MMIO_ADDR_W-1:0] addr,
                                      output logic [`MMIO_DATA_W-1:0] data);
    data = '0;
    case (addr)
      mmio_pkg::CU_RETURN:         data = cu_return;
      mmio_pkg::CU_RETURN_DONE:    data = cu_return_done;
      mmio_pkg::ERROR_REG:         data = report_errors;
      mmio_pkg::AFU_STATUS:        data = afu_status;
      mmio_pkg::CU_STATUS:         data = cu_status;
      mmio_pkg::DONE_COUNT_REG:    data = done_count;
      mmio_pkg::FLUSHED_COUNT_REG: data = flushed_count;
      mmio_pkg::CYCLE_COUNT_REG:   data = cycle_count;
      default:                     return 1'b0;
    endcase
    return 1'b1;
  endfunction

  // Selectors 0 to 5 are writable, 6 to 13 readable, the rest unmapped
  function automatic logic [`MMIO_ADDR_W-1:0] pick_reg_addr(input int sel);
    case (sel)
      0:       return mmio_pkg::AFU_CONFIGURE;
      1:       return mmio_pkg::AFU_CONFIGURE_2;
      2:       return mmio_pkg::CU_CONFIGURE;
      3:       return mmio_pkg::CU_CONFIGURE_2;
      4:       return mmio_pkg::CU_RETURN_DONE_ACK;
      5:       return mmio_pkg::ERROR_REG_ACK;
      6:       return mmio_pkg::CU_RETURN;
      7:       return mmio_pkg::CU_RETURN_DONE;
      8:       return mmio_pkg::ERROR_REG;
      9:       return mmio_pkg::AFU_STATUS;
      10:      return mmio_pkg::CU_STATUS;
      11:      return mmio_pkg::DONE_COUNT_REG;
      12:      return mmio_pkg::FLUSHED_COUNT_REG;
      13:      return mmio_pkg::CYCLE_COUNT_REG;
      default: return 24'h12_3456;
    endcase
  endfunction

  function automatic logic [`MMIO_DATA_W-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_value(input string name, input logic [`MMIO_DATA_W-1:0] expected,
                             input logic [`MMIO_DATA_W-1:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor at mid cycle
  //////////////////////////////////////////////////
  task automatic check_cycle();
    expect_t strobe_exp;
    expect_t ack_exp;
    logic    ack_due;
    strobe_exp = '0;
    ack_exp    = '0;
    ack_due    = 1'b0;
    // Strobes lead the ack by one cycle
    foreach (model_q[i]) begin
      if (model_q[i].ack_cycle == cycle + 1) begin
        strobe_exp = model_q[i];
      end
    end
    if (model_q.size() > 0 && model_q[0].ack_cycle <= cycle) begin
      ack_due = 1'b1;
      ack_exp = model_q.pop_front();
    end
    check_value("mmio_ack", ack_due, mmio_ack);
    check_value("mmio_errors", ack_exp.errors, mmio_errors);
    if (ack_due) begin
      check_value("mmio_rdata", ack_exp.rdata, mmio_rdata);
      check_value("mmio_rdata_parity", calc_odd_parity(ack_exp.rdata), mmio_rdata_parity);
    end
    check_value("afu_configure",
                (strobe_exp.strobe_sel == 3'd1) ? strobe_exp.strobe_data : 64'd0, afu_configure);
    check_value("afu_configure_2",
                (strobe_exp.strobe_sel == 3'd2) ? strobe_exp.strobe_data : 64'd0, afu_configure_2);
    check_value("cu_configure",
                (strobe_exp.strobe_sel == 3'd3) ? strobe_exp.strobe_data : 64'd0, cu_configure);
    check_value("cu_configure_2",
                (strobe_exp.strobe_sel == 3'd4) ? strobe_exp.strobe_data : 64'd0, cu_configure_2);
    check_value("cu_return_done_ack", strobe_exp.done_ack, cu_return_done_ack);
    check_value("report_errors_ack", strobe_exp.err_ack, report_errors_ack);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic drive_request(input logic cfg, input logic read, input logic dw,
                               input logic [`MMIO_ADDR_W-1:0] addr,
                               input logic [`MMIO_DATA_W-1:0] wdata,
                               input logic flip_ap, input logic flip_dp);
    expect_t                 exp;
    logic [`MMIO_DATA_W-1:0] dword;
    logic [`MMIO_DATA_W-1:0] status;
    exp           = '0;
    exp.ack_cycle = cycle + 3;
    exp.errors    = {!read && flip_dp, flip_ap};
    if (cfg && read) begin
      dword = desc_word(addr[`MMIO_ADDR_W-1:1]);
      if (dw) begin
        model_rdata = dword;
      end else if (addr[0]) begin
        model_rdata = {2{dword[31:0]}};
      end else begin
        model_rdata = {2{dword[63:32]}};
      end
    end else if (read) begin
      if (reg_lookup(addr, status)) begin
        model_rdata = status;
      end
    end else if (!cfg) begin
      exp.strobe_data = wdata;
      case (addr)
        mmio_pkg::AFU_CONFIGURE:      exp.strobe_sel = 3'd1;
        mmio_pkg::AFU_CONFIGURE_2:    exp.strobe_sel = 3'd2;
        mmio_pkg::CU_CONFIGURE:       exp.strobe_sel = 3'd3;
        mmio_pkg::CU_CONFIGURE_2:     exp.strobe_sel = 3'd4;
        mmio_pkg::CU_RETURN_DONE_ACK: exp.done_ack = |wdata;
        mmio_pkg::ERROR_REG_ACK:      exp.err_ack = |wdata;
        default: ;
      endcase
    end
    exp.rdata = model_rdata;
    model_q.push_back(exp);
    mmio_valid          = 1'b1;
    mmio_cfg            = cfg;
    mmio_read           = read;
    mmio_doubleword     = dw;
    mmio_address        = addr;
    mmio_address_parity = calc_odd_parity({40'd0, addr}) ^ flip_ap;
    mmio_wdata          = wdata;
    mmio_wdata_parity   = calc_odd_parity(wdata) ^ flip_dp;
    @(posedge clock);
    #2;
  endtask

  task automatic drive_idle();
    logic [31:0] junk;
    junk         = $random(seed);
    mmio_valid   = 1'b0;
    mmio_address = junk[`MMIO_ADDR_W-1:0];
    @(posedge clock);
    #2;
  endtask

  task automatic randomize_status();
    cu_return      = rand_word();
    cu_return_done = rand_word();
    report_errors  = rand_word();
    afu_status     = rand_word();
    cu_status      = rand_word();
    done_count     = rand_word();
    flushed_count  = rand_word();
    cycle_count    = rand_word();
  endtask

  task automatic issue_random_request();
    int                      sel;
    int                      idx;
    logic                    cfg;
    logic [`MMIO_ADDR_W-1:0] addr;
    logic [`MMIO_DATA_W-1:0] wdata;
    sel   = $unsigned($random(seed)) % 16;
    idx   = $unsigned($random(seed)) % (`AFU_DESC_WORDS + 2);
    cfg   = ($random(seed) & 3) == 0;
    addr  = cfg ? {idx[`AFU_DESC_IDX_W-1:0], 1'($random(seed))} : pick_reg_addr(sel);
    // Zero data now and then, so ack pulses stay quiet
    wdata = (($random(seed) & 7) == 0) ? 64'd0 : rand_word();
    randomize_status();
    drive_request(cfg, 1'($random(seed)), 1'($random(seed)), addr, wdata,
                  ($random(seed) & 15) == 0, ($random(seed) & 15) == 0);
  endtask

  task automatic finish_test(input string name);
    int waited;
    mmio_valid = 1'b0;
    waited     = 0;
    while (model_q.size() > 0 && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    #2;
    assert (model_q.size() == 0) else begin
      $display("Error at %0t ns: no acknowledge within timeout", $time);
      error_count++;
      model_q.delete();
    end
    $display("test %s finished with %0d errors", name, error_count - test_start);
    test_start = error_count;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [`MMIO_DATA_W-1:0] dword;
    int                      n;
    seed        = 32'h85cd_ea90;
    cycle       = 0;
    error_count = 0;
    check_count = 0;
    test_start  = 0;
    monitor_on  = 1'b0;
    model_rdata = '0;
    rstn        = 1'b0;
    mmio_valid  = 1'b0;
    mmio_cfg    = 1'b0;
    mmio_read   = 1'b0;
    mmio_doubleword     = 1'b0;
    mmio_address        = '0;
    mmio_address_parity = 1'b1;
    mmio_wdata          = '0;
    mmio_wdata_parity   = 1'b1;
    randomize_status();
    repeat (3) @(posedge clock);
    #2;
    rstn = 1'b1;

    // 1 Reset state
    check_value("mmio_ack", 0, mmio_ack);
    check_value("mmio_errors", 0, mmio_errors);
    check_value("afu_configure", 0, afu_configure);
    check_value("afu_configure_2", 0, afu_configure_2);
    check_value("cu_configure", 0, cu_configure);
    check_value("cu_configure_2", 0, cu_configure_2);
    check_value("cu_return_done_ack", 0, cu_return_done_ack);
    check_value("report_errors_ack", 0, report_errors_ack);
    check_value("mmio_rdata", 0, mmio_rdata);
    check_value("mmio_rdata_parity", 1, mmio_rdata_parity);
    monitor_on = 1'b1;
    finish_test("reset_state");

    // 2 Descriptor fields, then every index in all three formats
    dword = desc_word(0);
    check_value("descriptor num_of_processes", 1, dword[47:32]);
    check_value("descriptor num_of_afu_crs", 1, dword[31:16]);
    dword = desc_word(5);
    check_value("descriptor afu_cr_offset", 64'h100, dword);
    dword = desc_word(6);
    check_value("descriptor psa_required", 1, dword[56]);
    for (int idx = 0; idx < `AFU_DESC_WORDS + 2; idx++) begin
      drive_request(1'b1, 1'b1, 1'b1, {idx[22:0], 1'b0}, rand_word(), 1'b0, 1'b0);
      drive_request(1'b1, 1'b1, 1'b0, {idx[22:0], 1'b0}, rand_word(), 1'b0, 1'b0);
      drive_request(1'b1, 1'b1, 1'b0, {idx[22:0], 1'b1}, rand_word(), 1'b0, 1'b0);
    end
    finish_test("config_reads");

    // 3 Random then zero data to each writable address
    for (int sel = 0; sel < 6; sel++) begin
      drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(sel), rand_word(), 1'b0, 1'b0);
      drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(sel), 64'd0, 1'b0, 1'b0);
    end
    drive_request(1'b1, 1'b0, 1'b1, 24'h00_0004, rand_word(), 1'b0, 1'b0);
    drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(14), rand_word(), 1'b0, 1'b0);
    finish_test("register_writes");

    // 4 Status reads with stable inputs
    randomize_status();
    for (int sel = 6; sel < 14; sel++) begin
      drive_request(1'b0, 1'b1, 1'b1, pick_reg_addr(sel), rand_word(), 1'b0, 1'b0);
      drive_request(1'b0, 1'b1, 1'b1, pick_reg_addr(14), rand_word(), 1'b0, 1'b0);
    end
    finish_test("status_reads");

    // 5 Parity errors
    drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(0), rand_word(), 1'b1, 1'b0);
    drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(2), rand_word(), 1'b0, 1'b1);
    drive_request(1'b0, 1'b1, 1'b1, pick_reg_addr(9), rand_word(), 1'b0, 1'b1);
    drive_request(1'b1, 1'b1, 1'b1, 24'h00_0002, rand_word(), 1'b1, 1'b0);
    drive_request(1'b0, 1'b0, 1'b1, pick_reg_addr(3), rand_word(), 1'b1, 1'b1);
    drive_idle();
    drive_request(1'b1, 1'b0, 1'b1, 24'h00_0006, rand_word(), 1'b0, 1'b1);
    finish_test("parity_errors");

    // 6 Mixed back-to-back stream
    n = 0;
    while (n < 200) begin
      if (($random(seed) & 7) == 0) begin
        drive_idle();
      end else begin
        issue_random_request();
        n++;
      end
    end
    finish_test("random_stream");

    $display("tests run: 6, checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- mmio_top.f
+incdir+hdl
hdl/mmio_pkg.sv
hdl/afu_pkg.sv
hdl/mmio_request_capture.sv
hdl/mmio_register_file.sv
hdl/mmio_response.sv
hdl/mmio_top.sv
dv/mmio_tb.sv

//--- Bender.yml
package:
  name: mmio_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mmio_pkg.sv
      - hdl/afu_pkg.sv
      - hdl/mmio_request_capture.sv
      - hdl/mmio_register_file.sv
      - hdl/mmio_response.sv
      - hdl/mmio_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/mmio_tb.sv
